// ==== armExecCore.f ====
+incdir+verilog
verilog/armIsaPkg.sv
verilog/wbMapPkg.sv
verilog/wbSlavePort.sv
verilog/instrDecoder.sv
verilog/barrelShifter.sv
verilog/aluFlags.sv
verilog/registerFile.sv
verilog/armExecCore.sv
tests/clockGen.sv
tests/armExecCoreTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the execute core testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1
simOut=""
verilator --binary --assert -j 0 -f armExecCore.f --top-module armExecCoreTb -o armExecCoreSim \
  && simOut="$(./obj_dir/armExecCoreSim 2>&1)"
printf '%s\n' "$simOut"
grep -q "All tests passed!" <<< "$simOut" && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }

// ==== tests/armExecCoreTb.sv ====
/* Execute core testbench */

`timescale 1ns/1ps
`default_nettype none

`include "armCore_params.svh"

module armExecCoreTb;

  import armIsaPkg::*;
  import wbMapPkg::*;

  typedef logic [`DATA_WIDTH-1:0] wordT;

  typedef enum logic [1:0] {
    kindWrite     = 2'd0,  // Register or port write
    kindInstr     = 2'd1,
    kindRead      = 2'd2,
    kindFlagsRead = 2'd3
  } rowKindT;

  typedef struct packed {
    rowKindT kind;
    wbAdrT   adr;
    wordT    data;
    wordT    expected;  // Used by read rows only
  } rowT;

  localparam int ackTimeout   = 20;  // Cycles per bus access
  localparam int resetTimeout = 50;

  logic  Clk;
  logic  Reset;
  logic  wbCyc;
  logic  wbStb;
  logic  wbWe;
  wbAdrT wbAdr;
  wordT  wbDatW;
  wordT  wbDatR;
  logic  wbAck;

  rowT         rows[$];
  string       rowNames[$];
  wordT        modelRegs [`REG_COUNT];
  flagsT       modelFlags;
  logic [31:0] rngState;
  int          waitCount;

  clockGen clock_i (
    .Clk   (Clk),
    .Reset (Reset)
  );

  armExecCore dut_i (
    .Clk    (Clk),
    .Reset  (Reset),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck)
  );

  task automatic abortRun();
    $display("Test failures found");
    $fatal(1, "stopped at the first failure");
  endtask

  task automatic compareWord(input string name, input wordT expected, input wordT actual);
    if (actual !== expected) begin
      $display("error %s: expected %h, actual %h", name, expected, actual);
      abortRun();
    end
  endtask

  task automatic compareFlags(input string name, input flagsT expected, input flagsT actual);
    if (actual !== expected) begin
      $display("error %s: expected NZCV %b, actual NZCV %b", name, expected, actual);
      abortRun();
    end
  endtask

  // One classic cycle, driven on the falling edge
  task automatic busAccess(input logic we, input wbAdrT adr, input wordT data,
                           output wordT readData);
    int cycles;
    @(negedge Clk);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = we;
    wbAdr  = adr;
    wbDatW = data;
    cycles = 0;
    while (wbAck !== 1'b1) begin
      if (cycles == ackTimeout) begin
        $display("No acknowledge arrived for the bus access at address %0d", adr);
        abortRun();
      end
      @(negedge Clk);
      cycles++;
    end
    readData = wbDatR;
    wbCyc    = 1'b0;
    wbStb    = 1'b0;
    wbWe     = 1'b0;
  endtask

  task automatic applyRow(input rowT row, input string name);
    wordT word;
    case (row.kind)
      kindRead: begin
        busAccess(1'b0, row.adr, '0, word);
        compareWord(name, row.expected, word);
      end
      kindFlagsRead: begin
        busAccess(1'b0, row.adr, '0, word);
        compareFlags(name, flagsT'(row.expected[`DATA_WIDTH-1 -: 4]),
                     flagsT'(word[`DATA_WIDTH-1 -: 4]));
      end
      default: busAccess(1'b1, row.adr, row.data, word);
    endcase
  endtask

  function automatic logic [31:0] nextRandom();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  function automatic wordT encodeRegOp(aluOpT op, logic s, regIndexT rd, regIndexT rn,
                                       regIndexT rm, shiftModeT mode, logic [4:0] amount);
    return {4'hE, 3'b000, op, s, rn, rd, amount, mode, 1'b0, rm};
  endfunction

  function automatic wordT encodeImmOp(aluOpT op, logic s, regIndexT rd, regIndexT rn,
                                       logic [3:0] rot, logic [7:0] imm);
    return {4'hE, 3'b001, op, s, rn, rd, rot, imm};
  endfunction

  function automatic wordT rotateWord(wordT value, logic [4:0] amount);
    if (amount == 5'd0) begin
      return value;
    end else begin
      return (value >> amount) | (value << (6'd32 - {1'b0, amount}));
    end
  endfunction

  function automatic wordT shiftWord(wordT value, shiftModeT mode, logic [4:0] amount);
    logic [63:0] extended;
    extended = {{32{value[31]}}, value} >> amount;  // Sign fill for ASR
    if (amount == 5'd0) begin
      return value;
    end
    case (mode)
      shLsl:   return value << amount;
      shLsr:   return value >> amount;
      shAsr:   return extended[31:0];
      default: return rotateWord(value, amount);
    endcase
  endfunction

  // Reference model of one instruction on modelRegs and modelFlags
  function automatic void modelExecute(wordT ins);
    aluOpT       op;
    wordT        a;
    wordT        b;
    wordT        x;
    wordT        y;
    wordT        res;
    logic [63:0] wide;
    longint      exact;
    logic        extra;
    logic        carry;
    logic        isCompare;
    logic        isAdd;
    logic        isSub;
    if (ins[27:25] == 3'b001) begin
      b = rotateWord({24'd0, ins[7:0]}, {ins[11:8], 1'b0});
    end else if (ins[27:25] == 3'b000 && !ins[4]) begin
      b = shiftWord(modelRegs[ins[3:0]], shiftModeT'(ins[6:5]), ins[11:7]);
    end else begin
      return;  // Not a supported form
    end
    op        = aluOpT'(ins[24:21]);
    a         = modelRegs[ins[19:16]];
    isCompare = op inside {opTst, opTeq, opCmp, opCmn};
    isAdd     = op inside {opAdd, opAdc, opCmn};
    isSub     = op inside {opSub, opSbc, opRsb, opRsc, opCmp};
    x         = (op inside {opRsb, opRsc}) ? b : a;  // Reverse ops swap operands
    y         = (op inside {opRsb, opRsc}) ? a : b;
    carry     = modelFlags.c;
    exact     = 0;
    res       = '0;
    if (isAdd) begin
      extra = (op == opAdc) ? modelFlags.c : 1'b0;
      wide  = {32'd0, x} + {32'd0, y} + {63'd0, extra};
      res   = wide[31:0];
      carry = wide[32];
      exact = longint'($signed(x)) + longint'($signed(y)) + longint'(extra);
    end else if (isSub) begin
      extra = (op inside {opSbc, opRsc}) ? !modelFlags.c : 1'b0;  // Borrow in
      res   = x - y - {31'd0, extra};
      carry = {32'd0, x} >= ({32'd0, y} + {63'd0, extra});  // Set when no borrow
      exact = longint'($signed(x)) - longint'($signed(y)) - longint'(extra);
    end else begin
      case (op)
        opAnd, opTst: res = a & b;
        opEor, opTeq: res = a ^ b;
        opOrr:        res = a | b;
        opMov:        res = b;
        opBic:        res = a & ~b;
        default:      res = ~b;
      endcase
    end
    if (!isCompare) begin
      modelRegs[ins[15:12]] = res;
    end
    if (isCompare || ins[20]) begin
      modelFlags.n = res[31];
      modelFlags.z = (res == '0);
      if (isAdd || isSub) begin
        modelFlags.c = carry;
        modelFlags.v = (exact != longint'($signed(res)));
      end
    end
  endfunction

  function automatic void addRow(rowKindT kind, wbAdrT adr, wordT data, wordT expected,
                                 string name);
    rowT row;
    row.kind     = kind;
    row.adr      = adr;
    row.data     = data;
    row.expected = expected;
    rows.push_back(row);
    rowNames.push_back(name);
  endfunction

  function automatic void putReg(regIndexT idx, wordT value);
    addRow(kindWrite, wbAdrT'(idx), value, '0, $sformatf("write r%0d", idx));
    modelRegs[idx] = value;
  endfunction

  function automatic void issueInstr(wordT ins, string name);
    addRow(kindInstr, wbAdrT'(`ADR_INSTR), ins, '0, name);
    modelExecute(ins);
  endfunction

  function automatic void expectReg(regIndexT idx, string name);
    addRow(kindRead, wbAdrT'(idx), '0, modelRegs[idx], name);
  endfunction

  function automatic void expectFlags(string name);
    addRow(kindFlagsRead, wbAdrT'(`ADR_FLAGS), '0,
           {modelFlags, {(`DATA_WIDTH-4){1'b0}}}, name);
  endfunction

  function automatic void buildResetChecks();
    for (int i = 0; i < `REG_COUNT; i++) begin
      addRow(kindRead, wbAdrT'(i), '0, 32'h0, $sformatf("reset r%0d", i));
    end
    addRow(kindFlagsRead, wbAdrT'(`ADR_FLAGS), '0, 32'h0, "reset flags");
    for (int i = 0; i < `REG_COUNT; i++) begin
      putReg(regIndexT'(i), nextRandom());
      expectReg(regIndexT'(i), $sformatf("readback r%0d", i));
    end
    addRow(kindRead, wbAdrT'(`ADR_INSTR), '0, 32'h0, "instr port reads zero");
    addRow(kindRead, 5'd18, '0, 32'h0, "unmapped reads zero");
  endfunction

  function automatic void buildLogicChecks();
    putReg(4'd1, 32'hF0F0_1234);
    putReg(4'd2, 32'h0FF0_FF00);
    issueInstr(encodeRegOp(opCmp, 1'b1, 4'd0, 4'd1, 4'd1, shLsl, 5'd0), "cmp equal");
    issueInstr(encodeRegOp(opAnd, 1'b0, 4'd3, 4'd1, 4'd2, shLsl, 5'd0), "and");
    addRow(kindRead, 5'd3, '0, 32'h00F0_1200, "and hand value");
    issueInstr(encodeRegOp(opEor, 1'b0, 4'd4, 4'd1, 4'd2, shLsr, 5'd8), "eor lsr");
    issueInstr(encodeRegOp(opOrr, 1'b0, 4'd5, 4'd1, 4'd2, shLsl, 5'd4), "orr lsl");
    issueInstr(encodeRegOp(opBic, 1'b0, 4'd6, 4'd1, 4'd2, shLsl, 5'd0), "bic");
    issueInstr(encodeRegOp(opMov, 1'b0, 4'd7, 4'd0, 4'd1, shAsr, 5'd4), "mov asr");
    issueInstr(encodeRegOp(opMvn, 1'b0, 4'd8, 4'd0, 4'd1, shLsl, 5'd0), "mvn");
    for (int i = 3; i <= 8; i++) begin
      expectReg(regIndexT'(i), $sformatf("logic result r%0d", i));
    end
    expectFlags("flags kept without S");
    issueInstr(encodeRegOp(opAnd, 1'b1, 4'd9, 4'd1, 4'd1, shLsl, 5'd0), "ands negative");
    expectReg(4'd9, "ands negative");
    expectFlags("ands keeps C and V");
  endfunction

  function automatic void checkFlaggedOp(aluOpT op, regIndexT rn, regIndexT rm, string name);
    issueInstr(encodeRegOp(op, 1'b1, 4'd0, rn, rm, shLsl, 5'd0), name);
    expectReg(4'd0, name);
    expectFlags({name, " flags"});
  endfunction

  function automatic void buildArithChecks();
    putReg(4'd10, 32'h7FFF_FFFF);
    putReg(4'd11, 32'h0000_0001);
    putReg(4'd12, 32'hFFFF_FFFF);
    putReg(4'd13, 32'h8000_0000);
    checkFlaggedOp(opAdd, 4'd10, 4'd11, "adds overflow");
    addRow(kindFlagsRead, wbAdrT'(`ADR_FLAGS), '0, 32'h9000_0000, "adds overflow hand");
    checkFlaggedOp(opAdd, 4'd12, 4'd11, "adds carry zero");
    checkFlaggedOp(opAdc, 4'd11, 4'd11, "adcs carry in");
    checkFlaggedOp(opSub, 4'd11, 4'd11, "subs zero");
    checkFlaggedOp(opSub, 4'd13, 4'd11, "subs overflow");
    checkFlaggedOp(opRsb, 4'd12, 4'd11, "rsbs");
    checkFlaggedOp(opSbc, 4'd11, 4'd12, "sbcs borrow");
    checkFlaggedOp(opRsc, 4'd11, 4'd13, "rscs");
  endfunction

  function automatic void buildCompareChecks();
    putReg(4'd14, 32'h1234_5678);
    issueInstr(encodeRegOp(opTst, 1'b1, 4'd14, 4'd1, 4'd2, shLsl, 5'd0), "tst");
    expectReg(4'd14, "tst keeps rd");
    expectFlags("tst flags");
    issueInstr(encodeRegOp(opTeq, 1'b1, 4'd14, 4'd1, 4'd1, shLsl, 5'd0), "teq");
    expectReg(4'd14, "teq keeps rd");
    expectFlags("teq flags");
    issueInstr(encodeRegOp(opCmp, 1'b1, 4'd14, 4'd11, 4'd12, shLsl, 5'd0), "cmp");
    expectReg(4'd14, "cmp keeps rd");
    expectFlags("cmp flags");
    issueInstr(encodeRegOp(opCmn, 1'b1, 4'd14, 4'd12, 4'd11, shLsl, 5'd0), "cmn");
    expectReg(4'd14, "cmn keeps rd");
    addRow(kindFlagsRead, wbAdrT'(`ADR_FLAGS), '0, 32'h6000_0000, "cmn flags hand");
  endfunction

  function automatic void buildShifterChecks();
    logic [4:0] amounts [3];
    amounts = '{5'd0, 5'd4, 5'd31};
    issueInstr(encodeImmOp(opMov, 1'b0, 4'd0, 4'd0, 4'd0, 8'h5A), "mov imm");
    expectReg(4'd0, "mov imm no rotate");
    issueInstr(encodeImmOp(opMov, 1'b0, 4'd0, 4'd0, 4'd4, 8'hFF), "mov imm ror 8");
    addRow(kindRead, 5'd0, '0, 32'hFF00_0000, "mov imm ror 8");
    issueInstr(encodeImmOp(opMov, 1'b0, 4'd0, 4'd0, 4'd1, 8'h03), "mov imm ror 2");
    addRow(kindRead, 5'd0, '0, 32'hC000_0000, "mov imm ror 2");
    for (int m = 0; m < 4; m++) begin
      for (int k = 0; k < 3; k++) begin
        issueInstr(encodeRegOp(opMov, 1'b0, 4'd0, 4'd0, 4'd1, shiftModeT'(m), amounts[k]),
                   "mov shifted");
        expectReg(4'd0, $sformatf("mov shift mode %0d by %0d", m, amounts[k]));
      end
    end
    issueInstr(encodeRegOp(opMov, 1'b0, 4'd0, 4'd0, 4'd1, shRor, 5'd4), "mov ror 4");
    addRow(kindRead, 5'd0, '0, 32'h4F0F_0123, "mov ror 4 hand");
  endfunction

  function automatic void buildRandomChecks();
    wordT badShift;
    wordT badForm;
    for (int i = 0; i < 40; i++) begin
      putReg(4'd1, nextRandom());
      putReg(4'd2, nextRandom());
      issueInstr(encodeRegOp((i % 2 == 0) ? opAdd : opSub, 1'b1, 4'd3, 4'd1, 4'd2, shLsl,
                             5'd0), "random op");
      expectReg(4'd3, $sformatf("random %0d result", i));
      expectFlags($sformatf("random %0d flags", i));
    end
    // Register-specified shift and a load/store encoding
    badShift = encodeRegOp(opAdd, 1'b1, 4'd3, 4'd1, 4'd2, shLsl, 5'd0) | 32'h0000_0010;
    badForm  = (encodeImmOp(opMov, 1'b1, 4'd3, 4'd0, 4'd0, 8'h00) & ~32'h0E00_0000)
               | 32'h0400_0000;
    issueInstr(badShift, "register shift ignored");
    expectReg(4'd3, "register shift keeps rd");
    expectFlags("register shift keeps flags");
    issueInstr(badForm, "load form ignored");
    expectReg(4'd3, "load form keeps rd");
    expectFlags("load form keeps flags");
    addRow(kindWrite, wbAdrT'(`ADR_FLAGS), 32'hF000_0000, '0, "write flags port");
    expectFlags("flags port write ignored");
  endfunction

  initial begin
    wbCyc      = 1'b0;
    wbStb      = 1'b0;
    wbWe       = 1'b0;
    wbAdr      = '0;
    wbDatW     = '0;
    modelFlags = '0;
    rngState   = 32'd79890;
    for (int i = 0; i < `REG_COUNT; i++) begin
      modelRegs[i] = '0;
    end

    buildResetChecks();
    buildLogicChecks();
    buildArithChecks();
    buildCompareChecks();
    buildShifterChecks();
    buildRandomChecks();

    waitCount = 0;
    while (Reset !== 1'b0) begin
      if (waitCount == resetTimeout) begin
        $display("Reset was never released");
        abortRun();
      end
      @(negedge Clk);
      waitCount++;
    end

    for (int i = 0; i < rows.size(); i++) begin
      applyRow(rows[i], rowNames[i]);
    end

    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tests/clockGen.sv ====
/* Testbench clock and reset */

`timescale 1ns/1ps
`default_nettype none

module clockGen (
  output logic Clk,
  output logic Reset
);

  initial begin
    Clk = 1'b0;
    forever begin
      #10 Clk = ~Clk;  // 20 ns period
    end
  end

  initial begin
    Reset = 1'b1;
    repeat (4) @(posedge Clk);
    @(negedge Clk);
    Reset = 1'b0;  // Released away from the active edge
  end

endmodule

`default_nettype wire

// ==== verilog/armExecCore.sv ====
/* ARM execute core top level */

`timescale 1ns/1ps
`default_nettype none

`include "armCore_params.svh"

module armExecCore (
  input  logic                    Clk,
  input  logic                    Reset,
  input  logic                    wbCyc,
  input  logic                    wbStb,
  input  logic                    wbWe,
  input  wbMapPkg::wbAdrT         wbAdr,
  input  logic [`DATA_WIDTH-1:0]  wbDatW,
  output logic [`DATA_WIDTH-1:0]  wbDatR,
  output logic                    wbAck
);

  import armIsaPkg::*;

  logic [`DATA_WIDTH-1:0] instr;
  logic                   execute;
  logic                   busWrite;
  regIndexT               busWriteIndex;
  logic [`DATA_WIDTH-1:0] busWriteData;
  regIndexT               busReadIndex;
  logic [`DATA_WIDTH-1:0] busReadData;
  flagsT                  flags;

  aluOpT                  aluOp;
  operandKindT            operandKind;
  shiftModeT              shiftMode;
  logic [4:0]             shiftAmount;
  logic [11:0]            immField;
  regIndexT               rn;
  regIndexT               rm;
  regIndexT               rd;
  logic                   setFlags;
  logic                   writesResult;

  logic [`DATA_WIDTH-1:0] rnValue;
  logic [`DATA_WIDTH-1:0] rmValue;
  logic [`DATA_WIDTH-1:0] operand2;
  logic [`DATA_WIDTH-1:0] result;

  // Input side
  wbSlavePort slave_i (
    .Clk           (Clk),
    .Reset         (Reset),
    .wbCyc         (wbCyc),
    .wbStb         (wbStb),
    .wbWe          (wbWe),
    .wbAdr         (wbAdr),
    .wbDatW        (wbDatW),
    .busReadData   (busReadData),
    .flags         (flags),
    .wbAck         (wbAck),
    .wbDatR        (wbDatR),
    .instr         (instr),
    .execute       (execute),
    .busWrite      (busWrite),
    .busWriteIndex (busWriteIndex),
    .busWriteData  (busWriteData),
    .busReadIndex  (busReadIndex)
  );

  instrDecoder decoder_i (
    .instr        (instr),
    .aluOp        (aluOp),
    .operandKind  (operandKind),
    .shiftMode    (shiftMode),
    .shiftAmount  (shiftAmount),
    .immField     (immField),
    .rn           (rn),
    .rm           (rm),
    .rd           (rd),
    .setFlags     (setFlags),
    .writesResult (writesResult)
  );

  barrelShifter shifter_i (
    .operandKind (operandKind),
    .immField    (immField),
    .shiftMode   (shiftMode),
    .shiftAmount (shiftAmount),
    .rmValue     (rmValue),
    .operand2    (operand2)
  );

  aluFlags alu_i (
    .Clk      (Clk),
    .Reset    (Reset),
    .execute  (execute),
    .aluOp    (aluOp),
    .setFlags (setFlags),
    .a        (rnValue),
    .b        (operand2),
    .result   (result),
    .flags    (flags)
  );

  // Output side
  registerFile regFile_i (
    .Clk           (Clk),
    .Reset         (Reset),
    .busWrite      (busWrite),
    .busWriteIndex (busWriteIndex),
    .busWriteData  (busWriteData),
    .execute       (execute),
    .writesResult  (writesResult),
    .rd            (rd),
    .result        (result),
    .busReadIndex  (busReadIndex),
    .rn            (rn),
    .rm            (rm),
    .busReadData   (busReadData),
    .rnValue       (rnValue),
    .rmValue       (rmValue)
  );

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
/* Three-read-port register file */

`timescale 1ns/1ps
`default_nettype none

`include "armCore_params.svh"

module registerFile (
  input  logic                    Clk,
  input  logic                    Reset,
  input  logic                    busWrite,
  input  armIsaPkg::regIndexT     busWriteIndex,
  input  logic [`DATA_WIDTH-1:0]  busWriteData,
  input  logic                    execute,
  input  logic                    writesResult,
  input  armIsaPkg::regIndexT     rd,
  input  logic [`DATA_WIDTH-1:0]  result,
  input  armIsaPkg::regIndexT     busReadIndex,
  input  armIsaPkg::regIndexT     rn,
  input  armIsaPkg::regIndexT     rm,
  output logic [`DATA_WIDTH-1:0]  busReadData,
  output logic [`DATA_WIDTH-1:0]  rnValue,
  output logic [`DATA_WIDTH-1:0]  rmValue
);

  import armIsaPkg::*;

  logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];
  logic                   writeEnable;
  regIndexT               writeIndex;
  logic [`DATA_WIDTH-1:0] writeData;

  // Bus write and ALU writeback share one port
  assign writeEnable = busWrite || (execute && writesResult);
  assign writeIndex  = busWrite ? busWriteIndex : rd;
  assign writeData   = busWrite ? busWriteData : result;

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable) begin
      regs[writeIndex] <= writeData;
    end
  end

  assign busReadData = regs[busReadIndex];
  assign rnValue     = regs[rn];
  assign rmValue     = regs[rm];

  writePortExclusive: assert property (@(posedge Clk) disable iff (Reset)
    !(busWrite && execute));

endmodule

`default_nettype wire

// ==== verilog/aluFlags.sv ====
/* ALU with NZCV flag register */

`timescale 1ns/1ps
`default_nettype none

`include "armCore_params.svh"

module aluFlags (
  input  logic                    Clk,
  input  logic                    Reset,
  input  logic                    execute,
  input  armIsaPkg::aluOpT        aluOp,
  input  logic                    setFlags,
  input  logic [`DATA_WIDTH-1:0]  a,
  input  logic [`DATA_WIDTH-1:0]  b,
  output logic [`DATA_WIDTH-1:0]  result,
  output armIsaPkg::flagsT        flags
);

  import armIsaPkg::*;

  logic [`DATA_WIDTH-1:0] addA;
  logic [`DATA_WIDTH-1:0] addB;
  logic                   carryIn;
  logic                   isArith;
  logic [`DATA_WIDTH:0]   sum;
  logic                   overflow;
  flagsT                  nextFlags;

  // Subtraction adds the inverted operand, so carry means no borrow
  always_comb begin
    addA    = a;
    addB    = b;
    carryIn = 1'b0;
    isArith = 1'b1;
    case (aluOp)
      opAdd, opCmn: carryIn = 1'b0;
      opAdc:        carryIn = flags.c;
      opSub, opCmp: begin
        addB    = ~b;
        carryIn = 1'b1;
      end
      opSbc: begin
        addB    = ~b;
        carryIn = flags.c;  // Borrow is not C
      end
      opRsb: begin
        addA    = b;
        addB    = ~a;
        carryIn = 1'b1;
      end
      opRsc: begin
        addA    = b;
        addB    = ~a;
        carryIn = flags.c;
      end
      default: isArith = 1'b0;
    endcase
  end

  assign sum      = {1'b0, addA} + {1'b0, addB} + {{`DATA_WIDTH{1'b0}}, carryIn};
  assign overflow = (addA[`DATA_WIDTH-1] == addB[`DATA_WIDTH-1]) &&
                    (sum[`DATA_WIDTH-1] != addA[`DATA_WIDTH-1]);

  always_comb begin
    case (aluOp)
      opAnd, opTst: result = a & b;
      opEor, opTeq: result = a ^ b;
      opOrr:        result = a | b;
      opMov:        result = b;
      opBic:        result = a & ~b;
      opMvn:        result = ~b;
      default:      result = sum[`DATA_WIDTH-1:0];  // All arithmetic ops
    endcase
  end

  always_comb begin
    nextFlags.n = result[`DATA_WIDTH-1];
    nextFlags.z = (result == '0);
    nextFlags.c = isArith ? sum[`DATA_WIDTH] : flags.c;  // Logical ops keep C and V
    nextFlags.v = isArith ? overflow : flags.v;
  end

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      flags <= '0;
    end else if (execute && setFlags) begin
      flags <= nextFlags;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/barrelShifter.sv ====
/* Second operand shifter */

`timescale 1ns/1ps
`default_nettype none

`include "armCore_params.svh"

module barrelShifter (
  input  armIsaPkg::operandKindT  operandKind,
  input  logic [11:0]             immField,
  input  armIsaPkg::shiftModeT    shiftMode,
  input  logic [4:0]              shiftAmount,
  input  logic [`DATA_WIDTH-1:0]  rmValue,
  output logic [`DATA_WIDTH-1:0]  operand2
);

  import armIsaPkg::*;

  logic [4:0]             rotAmount;
  logic [`DATA_WIDTH-1:0] immValue;
  logic [`DATA_WIDTH-1:0] shifted;

  function automatic logic [`DATA_WIDTH-1:0] rotateRight(
    input logic [`DATA_WIDTH-1:0] value,
    input logic [4:0]             amount
  );
    logic [2*`DATA_WIDTH-1:0] pair;
    pair = {value, value} >> amount;
    return pair[`DATA_WIDTH-1:0];
  endfunction

  assign rotAmount = {immField[11:8], 1'b0};  // Twice the rotate field
  assign immValue  = rotateRight({{(`DATA_WIDTH-8){1'b0}}, immField[7:0]}, rotAmount);

  always_comb begin
    if (shiftAmount == 5'd0) begin
      shifted = rmValue;  // Zero amount passes Rm through
    end else begin
      case (shiftMode)
        shLsl:   shifted = rmValue << shiftAmount;
        shLsr:   shifted = rmValue >> shiftAmount;
        shAsr:   shifted = $signed(rmValue) >>> shiftAmount;
        default: shifted = rotateRight(rmValue, shiftAmount);  // ROR
      endcase
    end
  end

  assign operand2 = (operandKind == operandImm) ? immValue : shifted;

endmodule

`default_nettype wire

// ==== verilog/instrDecoder.sv ====
/* Data-processing decoder */

`timescale 1ns/1ps
`default_nettype none

`include "armCore_params.svh"

module instrDecoder (
  input  logic [`DATA_WIDTH-1:0]  instr,
  output armIsaPkg::aluOpT        aluOp,
  output armIsaPkg::operandKindT  operandKind,
  output armIsaPkg::shiftModeT    shiftMode,
  output logic [4:0]              shiftAmount,
  output logic [11:0]             immField,
  output armIsaPkg::regIndexT     rn,
  output armIsaPkg::regIndexT     rm,
  output armIsaPkg::regIndexT     rd,
  output logic                    setFlags,
  output logic                    writesResult
);

  import armIsaPkg::*;

  logic isImmForm;
  logic isRegForm;
  logic supported;
  logic isCompare;

  // Bit 4 set would be a register-specified shift
  assign isImmForm = (instr[27:25] == 3'b001);
  assign isRegForm = (instr[27:25] == 3'b000) && !instr[4];
  assign supported = isImmForm || isRegForm;

  // Operand and register fields
  assign aluOp       = aluOpT'(instr[24:21]);
  assign operandKind = isImmForm ? operandImm : operandReg;
  assign shiftMode   = shiftModeT'(instr[6:5]);
  assign shiftAmount = instr[11:7];
  assign immField    = instr[11:0];  // Rotate in 11:8, value in 7:0
  assign rn          = instr[19:16];
  assign rd          = instr[15:12];
  assign rm          = instr[3:0];

  always_comb begin
    case (aluOp)
      opTst, opTeq, opCmp, opCmn: isCompare = 1'b1;
      default:                    isCompare = 1'b0;
    endcase
  end

  // Unsupported encodings neither write nor touch NZCV
  always_comb begin
    if (!supported) begin
      writesResult = 1'b0;
      setFlags     = 1'b0;
    end else if (isCompare) begin
      writesResult = 1'b0;
      setFlags     = 1'b1;  // Compares always update flags
    end else begin
      writesResult = 1'b1;
      setFlags     = instr[20];  // S bit
    end
  end

endmodule

`default_nettype wire

// ==== verilog/wbSlavePort.sv ====
/* Wishbone classic slave port */

`timescale 1ns/1ps
`default_nettype none

`include "armCore_params.svh"

module wbSlavePort (
  input  logic                    Clk,
  input  logic                    Reset,
  input  logic                    wbCyc,
  input  logic                    wbStb,
  input  logic                    wbWe,
  input  wbMapPkg::wbAdrT         wbAdr,
  input  logic [`DATA_WIDTH-1:0]  wbDatW,
  input  logic [`DATA_WIDTH-1:0]  busReadData,
  input  armIsaPkg::flagsT        flags,
  output logic                    wbAck,
  output logic [`DATA_WIDTH-1:0]  wbDatR,
  output logic [`DATA_WIDTH-1:0]  instr,
  output logic                    execute,
  output logic                    busWrite,
  output armIsaPkg::regIndexT     busWriteIndex,
  output logic [`DATA_WIDTH-1:0]  busWriteData,
  output armIsaPkg::regIndexT     busReadIndex
);

  import armIsaPkg::*;
  import wbMapPkg::*;

  wbTargetT               target;
  logic                   request;
  logic [`DATA_WIDTH-1:0] readWord;

  assign request      = wbCyc && wbStb && !wbAck;  // New request, not yet acked
  assign busReadIndex = wbAdr[$bits(regIndexT)-1:0];

  always_comb begin
    if (wbAdr < `REG_COUNT) begin
      target = targetReg;
    end else if (wbAdr == `ADR_INSTR) begin
      target = targetInstr;
    end else if (wbAdr == `ADR_FLAGS) begin
      target = targetFlags;
    end else begin
      target = targetNone;
    end
  end

  always_comb begin
    case (target)
      targetReg:   readWord = busReadData;
      targetFlags: readWord = {flags, {(`DATA_WIDTH - $bits(flagsT)){1'b0}}};
      default:     readWord = '0;  // Instruction port and unmapped
    endcase
  end

  always_ff @(posedge Clk or posedge Reset) begin
    if (Reset) begin
      wbAck    <= 1'b0;
      execute  <= 1'b0;
      busWrite <= 1'b0;
      wbDatR   <= '0;
    end else begin
      wbAck    <= request;  // One cycle after the request is seen
      execute  <= request && wbWe && (target == targetInstr);
      busWrite <= request && wbWe && (target == targetReg);
      if (request && !wbWe) begin
        wbDatR <= readWord;
      end
    end
  end

  always_ff @(posedge Clk) begin
    if (request && wbWe && (target == targetReg)) begin
      busWriteIndex <= wbAdr[$bits(regIndexT)-1:0];
      busWriteData  <= wbDatW;
    end
    if (request && wbWe && (target == targetInstr)) begin
      instr <= wbDatW;  // Held for the execute cycle
    end
  end

  ackSinglePulse: assert property (@(posedge Clk) disable iff (Reset) wbAck |=> !wbAck);

endmodule

`default_nettype wire

// ==== verilog/wbMapPkg.sv ====
/* Wishbone address map types */

`default_nettype none

`include "armCore_params.svh"

package wbMapPkg;

  typedef logic [`WB_ADR_WIDTH-1:0] wbAdrT;

  // What a bus address selects
  typedef enum logic [1:0] {
    targetReg   = 2'b00,  // R0 to R15
    targetInstr = 2'b01,
    targetFlags = 2'b10,
    targetNone  = 2'b11   // Unmapped, reads as zero
  } wbTargetT;

endpackage

`default_nettype wire

// ==== verilog/armIsaPkg.sv ====
/* ARM instruction set types */

`default_nettype none

`include "armCore_params.svh"

package armIsaPkg;

  // Values follow instruction bits 24 to 21
  typedef enum logic [3:0] {
    opAnd = 4'h0,
    opEor = 4'h1,
    opSub = 4'h2,
    opRsb = 4'h3,
    opAdd = 4'h4,
    opAdc = 4'h5,
    opSbc = 4'h6,
    opRsc = 4'h7,
    opTst = 4'h8,
    opTeq = 4'h9,
    opCmp = 4'hA,
    opCmn = 4'hB,
    opOrr = 4'hC,
    opMov = 4'hD,
    opBic = 4'hE,
    opMvn = 4'hF
  } aluOpT;

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftModeT;

  typedef enum logic {
    operandImm = 1'b0,  // 8-bit value with 4-bit rotate
    operandReg = 1'b1   // Rm shifted by an immediate amount
  } operandKindT;

  typedef logic [$clog2(`REG_COUNT)-1:0] regIndexT;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flagsT;

endpackage

`default_nettype wire

// ==== verilog/armCore_params.svh ====
/* Execute core parameters */

`ifndef ARM_CORE_PARAMS_SVH
`define ARM_CORE_PARAMS_SVH

// Datapath
`define DATA_WIDTH    32        // Register and bus word width
`define REG_COUNT     16        // R0 to R15

// Bus word addresses
`define WB_ADR_WIDTH  5         // Covers registers plus two ports
`define ADR_INSTR     16        // Instruction port, write only
`define ADR_FLAGS     17        // NZCV in bits 31 to 28, read only

`endif
